// File: dv/io_platform_model.svh
/* Register model of the IO platform, with the APB transfer
   and rtc pulse tasks used by the testbench */

`ifndef IO_PLATFORM_MODEL_SVH
`define IO_PLATFORM_MODEL_SVH

logic [31:0] m_gpio_out;
logic        m_msip;
logic [63:0] m_mtime;
logic [63:0] m_mtimecmp;
int          rtc_rises;

// Byte lanes with their strobe set take the new data
function automatic logic [31:0] merge_bytes(
    input logic [31:0] cur,
    input logic [31:0] wdata,
    input logic [3:0]  strb
);
    logic [31:0] mask;
    mask = {{8{strb[3]}}, {8{strb[2]}}, {8{strb[1]}}, {8{strb[0]}}};
    return (cur & ~mask) | (wdata & mask);
endfunction

// One APB transfer with read data sampled in the middle of the access cycle
task automatic apb_xfer(
    input  logic [31:0] addr,
    input  logic        wr,
    input  logic [31:0] data,
    input  logic [3:0]  strb,
    output logic [31:0] rd,
    output logic        err
);
    int wait_cnt;
    @(posedge aclk);
    paddr   <= addr;
    pwrite  <= wr;
    pwdata  <= data;
    pstrb   <= strb;
    psel    <= 1'b1;
    penable <= 1'b0;
    @(posedge aclk);
    penable <= 1'b1;
    wait_cnt = 0;
    @(negedge aclk);
    while (!pready && wait_cnt < 8) begin
        @(negedge aclk);
        wait_cnt++;
    end
    if (!pready) begin
        errors++;
        $display("No pready for the transfer to address %h at %0t", addr, $time);
    end else if (wait_cnt != 0) begin
        errors++;
        $display("pready came %0d cycles late for address %h at %0t",
                 wait_cnt, addr, $time);
    end
    rd  = prdata;
    err = pslverr;
    // Edge that ends the access cycle
    @(posedge aclk);
    psel    <= 1'b0;
    penable <= 1'b0;
endtask

// Each pulse is one rtc rise followed by a quiet hold
task automatic pulse_rtc(input int count);
    repeat (count) begin
        @(posedge aclk);
        rtc <= 1'b1;
        repeat (3) @(posedge aclk);
        rtc <= 1'b0;
        repeat (2) @(posedge aclk);
        rtc_rises++;
        m_mtime = m_mtime + 64'd1;
    end
    repeat (4) @(posedge aclk);
endtask

// High half parked at all ones first to avoid a false compare in between
task automatic set_mtimecmp(input logic [63:0] value);
    logic [31:0] rd;
    logic        err;
    apb_xfer(cmp_hi_addr, 1'b1, 32'hffff_ffff, 4'hf, rd, err);
    apb_xfer(cmp_lo_addr, 1'b1, value[31:0], 4'hf, rd, err);
    apb_xfer(cmp_hi_addr, 1'b1, value[63:32], 4'hf, rd, err);
    m_mtimecmp = value;
endtask

`endif

// File: dv/io_platform_tb.sv
`timescale 1ns/1ps

/* IO platform testbench: random APB, gpio_in and rtc stimulus
   checked against a register model */

module io_platform_tb;

    localparam int gpio_w = 32;

    localparam io_bus_pkg::apb_addr_t out_addr =
        io_map_pkg::gpio_base + io_map_pkg::gpio_out_off;
    localparam io_bus_pkg::apb_addr_t in_addr =
        io_map_pkg::gpio_base + io_map_pkg::gpio_in_off;
    localparam io_bus_pkg::apb_addr_t msip_addr =
        io_map_pkg::clint_base + io_map_pkg::msip_off;
    localparam io_bus_pkg::apb_addr_t time_lo_addr =
        io_map_pkg::clint_base + io_map_pkg::mtime_lo_off;
    localparam io_bus_pkg::apb_addr_t time_hi_addr =
        io_map_pkg::clint_base + io_map_pkg::mtime_hi_off;
    localparam io_bus_pkg::apb_addr_t cmp_lo_addr =
        io_map_pkg::clint_base + io_map_pkg::mtimecmp_lo_off;
    localparam io_bus_pkg::apb_addr_t cmp_hi_addr =
        io_map_pkg::clint_base + io_map_pkg::mtimecmp_hi_off;

    logic                  aclk;
    logic                  rst_n;
    logic                  rtc;
    io_bus_pkg::apb_addr_t paddr;
    logic                  psel;
    logic                  penable;
    logic                  pwrite;
    io_bus_pkg::apb_data_t pwdata;
    io_bus_pkg::apb_strb_t pstrb;
    io_bus_pkg::apb_data_t prdata;
    logic                  pready;
    logic                  pslverr;
    logic [gpio_w-1:0]     gpio_in;
    logic [gpio_w-1:0]     gpio_out;
    logic                  sw_irq;
    logic                  timer_irq;
    int                    errors;
    int                    checks;
    logic [31:0]           rng_state;

    `include "io_platform_model.svh"

    io_platform #(.GPIO_W(gpio_w)) DUT (
        .aclk      (aclk),
        .rst_n     (rst_n),
        .rtc       (rtc),
        .paddr     (paddr),
        .psel      (psel),
        .penable   (penable),
        .pwrite    (pwrite),
        .pwdata    (pwdata),
        .pstrb     (pstrb),
        .prdata    (prdata),
        .pready    (pready),
        .pslverr   (pslverr),
        .gpio_in   (gpio_in),
        .gpio_out  (gpio_out),
        .sw_irq    (sw_irq),
        .timer_irq (timer_irq)
    );

    always #5 aclk = ~aclk;

    function automatic logic [31:0] next_rand();
        rng_state = rng_state ^ (rng_state << 13);
        rng_state = rng_state ^ (rng_state >> 17);
        rng_state = rng_state ^ (rng_state << 5);
        return rng_state;
    endfunction

    task automatic check_equal(input string name, input logic [63:0] expected,
                               input logic [63:0] actual);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("MISMATCH at %0t: %s expected %h got %h", $time, name, expected, actual);
        end
    endtask

    task automatic read_expect(input logic [31:0] addr, input string name,
                               input logic [31:0] expected);
        logic [31:0] rd;
        logic        err;
        apb_xfer(addr, 1'b0, 32'h0, 4'h0, rd, err);
        check_equal(name, expected, rd);
        check_equal({name, " pslverr"}, 64'd0, 64'(err));
    endtask

    initial begin
        logic [31:0] addr;
        logic [31:0] data;
        logic [31:0] rd;
        logic [3:0]  strb;
        logic        err;
        logic        irq_seen;
        int          cnt;
        aclk       = 1'b0;
        rst_n      = 1'b0;
        rtc        = 1'b0;
        paddr      = '0;
        psel       = 1'b0;
        penable    = 1'b0;
        pwrite     = 1'b0;
        pwdata     = '0;
        pstrb      = '0;
        gpio_in    = '0;
        errors     = 0;
        checks     = 0;
        rng_state  = 32'd53911;
        m_gpio_out = '0;
        m_msip     = 1'b0;
        m_mtime    = '0;
        m_mtimecmp = '1;
        rtc_rises  = 0;
        repeat (5) @(posedge aclk);
        rst_n <= 1'b1;

        //////////////////////////////////////////////////
        // Reset state
        //////////////////////////////////////////////////
        @(negedge aclk);
        check_equal("gpio_out", 64'd0, 64'(gpio_out));
        check_equal("sw_irq", 64'd0, 64'(sw_irq));
        check_equal("timer_irq", 64'd0, 64'(timer_irq));
        check_equal("pready", 64'd0, 64'(pready));
        read_expect(cmp_lo_addr, "mtimecmp_lo", 32'hffff_ffff);
        read_expect(cmp_hi_addr, "mtimecmp_hi", 32'hffff_ffff);

        //////////////////////////////////////////////////
        // GPIO output and input
        //////////////////////////////////////////////////
        repeat (20) begin
            data = next_rand();
            strb = 4'(next_rand());
            apb_xfer(out_addr, 1'b1, data, strb, rd, err);
            m_gpio_out = merge_bytes(m_gpio_out, data, strb);
            check_equal("write pslverr", 64'd0, 64'(err));
            @(negedge aclk);
            check_equal("gpio_out", 64'(m_gpio_out), 64'(gpio_out));
            read_expect(out_addr, "gpio_out readback", m_gpio_out);
        end
        repeat (10) begin
            data = next_rand();
            @(posedge aclk);
            gpio_in <= data;
            repeat (3) @(posedge aclk);
            read_expect(in_addr, "gpio_in", data);
        end
        // Input register is read only
        apb_xfer(in_addr, 1'b1, next_rand(), 4'hf, rd, err);
        check_equal("gpio_in write pslverr", 64'd1, 64'(err));
        read_expect(out_addr, "gpio_out readback", m_gpio_out);

        //////////////////////////////////////////////////
        // Unmapped hole and space above CLINT
        //////////////////////////////////////////////////
        repeat (16) begin
            if (1'(next_rand())) begin
                addr = 32'd8 + next_rand() % 32'd16;
            end else begin
                addr = 32'd44 + next_rand() % 32'd4096;
            end
            apb_xfer(addr, 1'(next_rand()), next_rand(), 4'hf, rd, err);
            check_equal("unmapped pslverr", 64'd1, 64'(err));
            check_equal("unmapped prdata", 64'd0, 64'(rd));
        end
        read_expect(out_addr, "gpio_out readback", m_gpio_out);
        read_expect(msip_addr, "msip", 32'(m_msip));
        read_expect(cmp_lo_addr, "mtimecmp_lo", m_mtimecmp[31:0]);
        read_expect(cmp_hi_addr, "mtimecmp_hi", m_mtimecmp[63:32]);

        //////////////////////////////////////////////////
        // mtime counting and interrupts
        //////////////////////////////////////////////////
        repeat (3) begin
            pulse_rtc(1 + int'(next_rand() % 32'd6));
            read_expect(time_lo_addr, "mtime_lo", m_mtime[31:0]);
            read_expect(time_hi_addr, "mtime_hi", m_mtime[63:32]);

            m_msip = 1'b1;
            apb_xfer(msip_addr, 1'b1, 32'h1, 4'h1, rd, err);
            @(negedge aclk);
            check_equal("sw_irq", 64'(m_msip), 64'(sw_irq));
            m_msip = 1'b0;
            apb_xfer(msip_addr, 1'b1, 32'h0, 4'h1, rd, err);
            @(negedge aclk);
            check_equal("sw_irq", 64'(m_msip), 64'(sw_irq));

            // Compare value at or below mtime
            set_mtimecmp(64'(next_rand()) % (m_mtime + 64'd1));
            cnt = 0;
            irq_seen = 1'b0;
            while (!irq_seen && cnt < 2) begin
                @(negedge aclk);
                irq_seen = timer_irq;
                cnt++;
            end
            if (!irq_seen) begin
                errors++;
                $display("timer_irq did not rise within 2 cycles at %0t", $time);
            end

            // Compare value above mtime
            set_mtimecmp(m_mtime + 64'd1 + 64'(next_rand() % 32'd64));
            repeat (4) begin
                @(negedge aclk);
                check_equal("timer_irq", 64'd0, 64'(timer_irq));
            end
        end

        $display("Checks: %0d  rtc rises: %0d  errors: %0d", checks, rtc_rises, errors);
        if (errors == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

// File: io_platform.f
+incdir+dv
source/io_bus_pkg.sv
source/io_map_pkg.sv
source/apb_io_decoder.sv
source/gpio_regs.sv
source/clint_timer.sv
source/io_platform.sv
dv/io_platform_tb.sv

// File: run_sim.sh
#!/bin/sh
# Build the IO platform testbench with Verilator and run it

cd "$(dirname "$0")" || exit 1

verilator --binary -Wno-fatal -f io_platform.f --top-module io_platform_tb \
    -Mdir obj_dir -o io_platform_sim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

out=$(./obj_dir/io_platform_sim)
status=$?
printf '%s\n' "$out"
if [ $status -ne 0 ]; then
    echo "Simulator exited with status $status"
    exit 1
fi

if printf '%s\n' "$out" | grep -qx "Simulation passed"; then
    exit 0
fi
echo "No pass report found in the simulation output"
exit 1

// File: source/apb_io_decoder.sv
`timescale 1ns/1ps

/* APB decoder: routes the bus to the GPIO or CLINT window, muxes
   the read data back and raises an error on unmapped addresses */

module apb_io_decoder (
    // Requester side
    input  io_bus_pkg::apb_addr_t paddr,
    input  logic                  psel,
    input  logic                  penable,
    output io_bus_pkg::apb_data_t prdata,
    output logic                  pready,
    output logic                  pslverr,
    // Slave side
    output logic                  gpio_sel,
    output logic                  clint_sel,
    output io_bus_pkg::apb_addr_t local_addr,
    input  io_bus_pkg::apb_data_t gpio_rdata,
    input  logic                  gpio_err,
    input  io_bus_pkg::apb_data_t clint_rdata,
    input  logic                  clint_err
);

    io_bus_pkg::apb_addr_t gpio_off;
    io_bus_pkg::apb_addr_t clint_off;
    logic                  gpio_hit;
    logic                  clint_hit;
    logic                  miss;
    logic                  slave_err;

    //////////////////////////////////////////////////
    // Window match
    //////////////////////////////////////////////////

    // Offset wraps below the base, so one unsigned compare covers both bounds
    assign gpio_off  = paddr - io_map_pkg::gpio_base;
    assign clint_off = paddr - io_map_pkg::clint_base;

    assign gpio_hit  = gpio_off < io_map_pkg::gpio_size;
    assign clint_hit = clint_off < io_map_pkg::clint_size;
    assign miss      = !gpio_hit && !clint_hit;

    assign gpio_sel  = psel & gpio_hit;
    assign clint_sel = psel & clint_hit;

    // Offset inside the selected window
    always_comb begin
        if (gpio_hit) begin
            local_addr = gpio_off;
        end else if (clint_hit) begin
            local_addr = clint_off;
        end else begin
            local_addr = '0;
        end
    end

    //////////////////////////////////////////////////
    // Response
    //////////////////////////////////////////////////

    // No wait states
    assign pready = psel & penable;

    // Unmapped reads return zero
    always_comb begin
        if (gpio_sel) begin
            prdata = gpio_rdata;
        end else if (clint_sel) begin
            prdata = clint_rdata;
        end else begin
            prdata = '0;
        end
    end

    // Slaves flag bad offsets or refused writes
    assign slave_err = (gpio_hit & gpio_err) | (clint_hit & clint_err);
    assign pslverr   = pready & (miss | slave_err);

endmodule

// File: source/clint_timer.sv
`timescale 1ns/1ps

/* CLINT slave: rtc-driven 64-bit mtime, mtimecmp and msip,
   with the software and timer interrupt lines */

module clint_timer (
    input  logic                  aclk,
    input  logic                  rst_n,
    input  logic                  rtc,
    input  logic                  sel,
    input  logic                  penable,
    input  logic                  pwrite,
    input  io_bus_pkg::apb_addr_t local_addr,
    input  io_bus_pkg::apb_data_t pwdata,
    input  io_bus_pkg::apb_strb_t pstrb,
    output io_bus_pkg::apb_data_t rdata,
    output logic                  err,
    output logic                  sw_irq,
    output logic                  timer_irq
);

    logic               rtc_meta;
    logic               rtc_sync;
    logic               rtc_last;
    logic               rtc_rise;
    logic               wr_en;
    logic               known_off;
    logic               msip;
    io_bus_pkg::mtime_t mtime;
    io_bus_pkg::mtime_t mtimecmp;

    //////////////////////////////////////////////////
    // rtc synchronizer and edge detect
    //////////////////////////////////////////////////

    always_ff @(posedge aclk or negedge rst_n) begin
        if (!rst_n) begin
            rtc_meta <= 1'b0;
            rtc_sync <= 1'b0;
            rtc_last <= 1'b0;
        end else begin
            rtc_meta <= rtc;
            rtc_sync <= rtc_meta;
            rtc_last <= rtc_sync;
        end
    end

    // One tick per rtc rise, counted on the third aclk edge
    assign rtc_rise = rtc_sync & ~rtc_last;

    //////////////////////////////////////////////////
    // Registers
    //////////////////////////////////////////////////

    assign wr_en = sel & penable & pwrite;

    // A bus write wins over the rtc tick
    always_ff @(posedge aclk or negedge rst_n) begin
        if (!rst_n) begin
            mtime <= '0;
        end else if (wr_en && local_addr == io_map_pkg::mtime_lo_off) begin
            mtime[0] <= io_bus_pkg::strb_merge(mtime[0], pwdata, pstrb);
        end else if (wr_en && local_addr == io_map_pkg::mtime_hi_off) begin
            mtime[1] <= io_bus_pkg::strb_merge(mtime[1], pwdata, pstrb);
        end else if (rtc_rise) begin
            mtime <= mtime + 1'b1;
        end
    end

    // Starts at all ones so no timer interrupt fires out of reset
    always_ff @(posedge aclk or negedge rst_n) begin
        if (!rst_n) begin
            mtimecmp <= '1;
        end else if (wr_en && local_addr == io_map_pkg::mtimecmp_lo_off) begin
            mtimecmp[0] <= io_bus_pkg::strb_merge(mtimecmp[0], pwdata, pstrb);
        end else if (wr_en && local_addr == io_map_pkg::mtimecmp_hi_off) begin
            mtimecmp[1] <= io_bus_pkg::strb_merge(mtimecmp[1], pwdata, pstrb);
        end
    end

    // msip holds bit 0 only
    always_ff @(posedge aclk or negedge rst_n) begin
        if (!rst_n) begin
            msip <= 1'b0;
        end else if (wr_en && local_addr == io_map_pkg::msip_off && pstrb[0]) begin
            msip <= pwdata[0];
        end
    end

    //////////////////////////////////////////////////
    // Interrupts
    //////////////////////////////////////////////////

    assign sw_irq = msip;

    // Unsigned 64-bit compare, one cycle late
    always_ff @(posedge aclk or negedge rst_n) begin
        if (!rst_n) begin
            timer_irq <= 1'b0;
        end else begin
            timer_irq <= mtime >= mtimecmp;
        end
    end

    //////////////////////////////////////////////////
    // Readback
    //////////////////////////////////////////////////

    always_comb begin
        rdata     = '0;
        known_off = 1'b1;
        case (local_addr)
            io_map_pkg::msip_off:        rdata = io_bus_pkg::apb_data_t'(msip);
            io_map_pkg::mtime_lo_off:    rdata = mtime[0];
            io_map_pkg::mtime_hi_off:    rdata = mtime[1];
            io_map_pkg::mtimecmp_lo_off: rdata = mtimecmp[0];
            io_map_pkg::mtimecmp_hi_off: rdata = mtimecmp[1];
            default:                     known_off = 1'b0;
        endcase
    end

    // All registers are writable, so only a bad offset is refused
    assign err = sel & ~known_off;

endmodule

// File: source/gpio_regs.sv
`timescale 1ns/1ps

/* GPIO slave: strobed output register and double-flopped input sampling */

module gpio_regs #(
    parameter int GPIO_W = 32
) (
    input  logic                  aclk,
    input  logic                  rst_n,
    input  logic                  sel,
    input  logic                  penable,
    input  logic                  pwrite,
    input  io_bus_pkg::apb_addr_t local_addr,
    input  io_bus_pkg::apb_data_t pwdata,
    input  io_bus_pkg::apb_strb_t pstrb,
    output io_bus_pkg::apb_data_t rdata,
    output logic                  err,
    input  logic [GPIO_W-1:0]     gpio_in,
    output logic [GPIO_W-1:0]     gpio_out
);

    logic [GPIO_W-1:0]     in_meta;
    logic [GPIO_W-1:0]     in_sync;
    io_bus_pkg::apb_data_t out_word;
    io_bus_pkg::apb_data_t out_next;
    logic                  is_out;
    logic                  is_in;
    logic                  out_wr;

    assign is_out = local_addr == io_map_pkg::gpio_out_off;
    assign is_in  = local_addr == io_map_pkg::gpio_in_off;

    //////////////////////////////////////////////////
    // Output register
    //////////////////////////////////////////////////

    assign out_word = io_bus_pkg::apb_data_t'(gpio_out);
    assign out_next = io_bus_pkg::strb_merge(out_word, pwdata, pstrb);
    assign out_wr   = sel & penable & pwrite & is_out;

    // Bits above GPIO_W are dropped
    always_ff @(posedge aclk or negedge rst_n) begin
        if (!rst_n) begin
            gpio_out <= '0;
        end else if (out_wr) begin
            gpio_out <= out_next[GPIO_W-1:0];
        end
    end

    //////////////////////////////////////////////////
    // Input synchronizer
    //////////////////////////////////////////////////

    always_ff @(posedge aclk or negedge rst_n) begin
        if (!rst_n) begin
            in_meta <= '0;
            in_sync <= '0;
        end else begin
            in_meta <= gpio_in;
            in_sync <= in_meta;
        end
    end

    // Readback, zero-extended
    always_comb begin
        if (is_out) begin
            rdata = out_word;
        end else if (is_in) begin
            rdata = io_bus_pkg::apb_data_t'(in_sync);
        end else begin
            rdata = '0;
        end
    end

    // Unknown offset, or a write to the input register
    assign err = sel & (!(is_out || is_in) || (pwrite && is_in));

endmodule

// File: source/io_bus_pkg.sv
/* APB bus widths and types for the IO platform,
   plus the CLINT counter width and the byte strobe merge */

package io_bus_pkg;

    //////////////////////////////////////////////////
    // Bus widths
    //////////////////////////////////////////////////

    localparam int apb_addr_w = 32;
    localparam int apb_data_w = 32;

    // mtime and mtimecmp span two data words
    localparam int mtime_w = 2 * apb_data_w;

    //////////////////////////////////////////////////
    // Bus types
    //////////////////////////////////////////////////

    typedef logic [apb_addr_w-1:0] apb_addr_t;
    typedef logic [apb_data_w-1:0] apb_data_t;
    typedef logic [apb_data_w/8-1:0] apb_strb_t;

    // Index 0 is the low word, index 1 the high word
    typedef logic [mtime_w/apb_data_w-1:0][apb_data_w-1:0] mtime_t;

    // Replace only the bytes whose strobe is set
    function automatic apb_data_t strb_merge(
        input apb_data_t cur,
        input apb_data_t wdata,
        input apb_strb_t strb
    );
        apb_data_t res;
        res = cur;
        for (int i = 0; i < apb_data_w / 8; i++) begin
            if (strb[i]) begin
                res[8*i +: 8] = wdata[8*i +: 8];
            end
        end
        return res;
    endfunction

endpackage

// File: source/io_map_pkg.sv
/* IO address map: the slave windows and the register offsets
   inside each window */

package io_map_pkg;

    //////////////////////////////////////////////////
    // Slave windows
    //////////////////////////////////////////////////

    // GPIO, two registers
    localparam io_bus_pkg::apb_addr_t gpio_base = 0;
    localparam io_bus_pkg::apb_addr_t gpio_size = 8;

    // Offsets 8 to 23 are an unmapped hole and answer with an error

    // CLINT, five registers
    localparam io_bus_pkg::apb_addr_t clint_base = 24;
    localparam io_bus_pkg::apb_addr_t clint_size = 20;

    //////////////////////////////////////////////////
    // GPIO register offsets
    //////////////////////////////////////////////////

    localparam io_bus_pkg::apb_addr_t gpio_out_off = 0;
    // Read only
    localparam io_bus_pkg::apb_addr_t gpio_in_off = 4;

    //////////////////////////////////////////////////
    // CLINT register offsets
    //////////////////////////////////////////////////

    localparam io_bus_pkg::apb_addr_t msip_off = 0;
    localparam io_bus_pkg::apb_addr_t mtime_lo_off = 4;
    localparam io_bus_pkg::apb_addr_t mtime_hi_off = 8;
    localparam io_bus_pkg::apb_addr_t mtimecmp_lo_off = 12;
    localparam io_bus_pkg::apb_addr_t mtimecmp_hi_off = 16;

endpackage

// File: source/io_platform.sv
`timescale 1ns/1ps

/* IO platform top: APB decoder in front of the GPIO and CLINT slaves */

module io_platform #(
    // Number of GPIO pins, 1 to 32
    parameter int GPIO_W = 32
) (
    // Clock and reset
    input  logic                  aclk,
    input  logic                  rst_n,
    // Real-time reference
    input  logic                  rtc,
    // APB completer
    input  io_bus_pkg::apb_addr_t paddr,
    input  logic                  psel,
    input  logic                  penable,
    input  logic                  pwrite,
    input  io_bus_pkg::apb_data_t pwdata,
    input  io_bus_pkg::apb_strb_t pstrb,
    output io_bus_pkg::apb_data_t prdata,
    output logic                  pready,
    output logic                  pslverr,
    // Pins and interrupts
    input  logic [GPIO_W-1:0]     gpio_in,
    output logic [GPIO_W-1:0]     gpio_out,
    output logic                  sw_irq,
    output logic                  timer_irq
);

    logic                  gpio_sel;
    logic                  clint_sel;
    io_bus_pkg::apb_addr_t local_addr;
    io_bus_pkg::apb_data_t gpio_rdata;
    logic                  gpio_err;
    io_bus_pkg::apb_data_t clint_rdata;
    logic                  clint_err;

    //////////////////////////////////////////////////
    // Address decode
    //////////////////////////////////////////////////

    apb_io_decoder u_decoder (
        .paddr       (paddr),
        .psel        (psel),
        .penable     (penable),
        .prdata      (prdata),
        .pready      (pready),
        .pslverr     (pslverr),
        .gpio_sel    (gpio_sel),
        .clint_sel   (clint_sel),
        .local_addr  (local_addr),
        .gpio_rdata  (gpio_rdata),
        .gpio_err    (gpio_err),
        .clint_rdata (clint_rdata),
        .clint_err   (clint_err)
    );

    //////////////////////////////////////////////////
    // Slaves
    //////////////////////////////////////////////////

    gpio_regs #(
        .GPIO_W (GPIO_W)
    ) u_gpio (
        .aclk       (aclk),
        .rst_n      (rst_n),
        .sel        (gpio_sel),
        .penable    (penable),
        .pwrite     (pwrite),
        .local_addr (local_addr),
        .pwdata     (pwdata),
        .pstrb      (pstrb),
        .rdata      (gpio_rdata),
        .err        (gpio_err),
        .gpio_in    (gpio_in),
        .gpio_out   (gpio_out)
    );

    clint_timer u_clint (
        .aclk       (aclk),
        .rst_n      (rst_n),
        .rtc        (rtc),
        .sel        (clint_sel),
        .penable    (penable),
        .pwrite     (pwrite),
        .local_addr (local_addr),
        .pwdata     (pwdata),
        .pstrb      (pstrb),
        .rdata      (clint_rdata),
        .err        (clint_err),
        .sw_irq     (sw_irq),
        .timer_irq  (timer_irq)
    );

endmodule
